// File: src/cpu_pkg.sv
package cpu_pkg;

        // tags count up by one and wrap, so a change is all a receiver looks for
        localparam int TAG_WIDTH = 4;

        localparam int REG_COUNT = 32;

        // x2 starts one word below the top of the data region
        localparam logic [31:0] SP_RESET = 32'h1000_03fc;

        // strobes must be this many cycles apart for the writeback to land in time
        localparam int MIN_STROBE_GAP = 3;

        typedef enum logic [6:0] {
                OPC_OP     = 7'b0110011,
                OPC_OP_IMM = 7'b0010011,
                OPC_LUI    = 7'b0110111
        } opcode_e;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_XOR,
                ALU_OR,
                ALU_AND,
                ALU_SLT,
                ALU_LUI
        } alu_op_e;

        // the fetch record carries new content whenever its tag changes
        typedef struct packed {
                logic [31:0]          instruction;
                logic [TAG_WIDTH-1:0] tag;
        } fetch_data_t;

        // writeback record from execute back into the register file
        typedef struct packed {
                logic [31:0]          rd;
                logic [4:0]           inst_rd;
                logic [TAG_WIDTH-1:0] tag;
        } memory_data_t;

endpackage

// File: src/cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch (
        input  logic                i_clock,
        input  logic                i_reset,
        input  logic                i_instr_strobe,
        input  logic [31:0]         i_instruction,
        output cpu_pkg::fetch_data_t o_fetch_data
);

        typedef logic [$clog2(cpu_pkg::MIN_STROBE_GAP + 1) - 1:0] gap_count_t;

        logic [31:0]                   instruction;
        logic [cpu_pkg::TAG_WIDTH-1:0] tag;
        gap_count_t                    gap_count;

        assign o_fetch_data.instruction = instruction;
        assign o_fetch_data.tag = tag;

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        tag <= '0;
                        // the first strobe after reset is always allowed
                        gap_count <= gap_count_t'(cpu_pkg::MIN_STROBE_GAP);
                end else begin
                        if (i_instr_strobe) begin
                                tag <= tag + 1'b1;
                                gap_count <= gap_count_t'(1);
                        end else if (gap_count < cpu_pkg::MIN_STROBE_GAP) begin
                                // saturates once the gap is long enough
                                gap_count <= gap_count + 1'b1;
                        end
                end
        end

        always_ff @(posedge i_clock) begin
                if (i_instr_strobe) begin
                        instruction <= i_instruction;
                end
        end

        // a closer strobe would read its operands before the previous result is written
        a_strobe_gap: assert property (
                @(posedge i_clock) disable iff (i_reset)
                i_instr_strobe |-> gap_count >= cpu_pkg::MIN_STROBE_GAP
        ) else $error("instruction strobes closer than %0d cycles",
                      cpu_pkg::MIN_STROBE_GAP);

endmodule

// File: src/cpu_registers.sv
`timescale 1ns/1ps

module cpu_registers (
        input  logic                  i_reset,
        input  logic                  i_clock,
        input  cpu_pkg::fetch_data_t  i_fetch_data,
        output logic [31:0]           o_rs1,
        output logic [31:0]           o_rs2,
        input  cpu_pkg::memory_data_t i_memory_data
);

        logic [31:0]                   regs [cpu_pkg::REG_COUNT];
        logic [31:0]                   rs1;
        logic [31:0]                   rs2;
        logic [cpu_pkg::TAG_WIDTH-1:0] read_tag;
        logic [cpu_pkg::TAG_WIDTH-1:0] write_tag;
        logic [4:0]                    inst_rs1;
        logic [4:0]                    inst_rs2;
        logic                          read_req;
        logic                          write_req;

        assign inst_rs1 = i_fetch_data.instruction[19:15];
        assign inst_rs2 = i_fetch_data.instruction[24:20];

        assign read_req = i_fetch_data.tag != read_tag;
        assign write_req = i_memory_data.tag != write_tag;

        assign o_rs1 = rs1;
        assign o_rs2 = rs2;

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        rs1 <= '0;
                        rs2 <= '0;
                        read_tag <= '0;
                        write_tag <= '0;
                        for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                                regs[i] <= (i == 2) ? cpu_pkg::SP_RESET : 32'h0;
                        end
                end else begin
                        if (read_req) begin
                                // x0 is hardwired to zero whatever was written to it
                                rs1 <= (inst_rs1 != 5'd0) ? regs[inst_rs1] : 32'h0;
                                rs2 <= (inst_rs2 != 5'd0) ? regs[inst_rs2] : 32'h0;
                                read_tag <= i_fetch_data.tag;
                        end
                        if (write_req) begin
                                regs[i_memory_data.inst_rd] <= i_memory_data.rd;
                                write_tag <= i_memory_data.tag;
                        end
                end
        end

        // a skipped tag value would mean execute issued a writeback this block never saw
        a_write_tag_step: assert property (
                @(posedge i_clock) disable iff (i_reset)
                write_req |-> i_memory_data.tag == write_tag + 1'b1
        ) else $error("writeback tag jumped from %0h to %0h",
                      write_tag, i_memory_data.tag);

endmodule

// File: src/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
        input  logic                  i_clock,
        input  logic                  i_reset,
        input  cpu_pkg::fetch_data_t  i_fetch_data,
        input  logic [31:0]           i_rs1,
        input  logic [31:0]           i_rs2,
        output cpu_pkg::memory_data_t o_memory_data,
        output logic                  o_result_valid,
        output logic [31:0]           o_result,
        output logic [4:0]            o_result_rd,
        output logic                  o_illegal
);

        logic [31:0]                   inst;
        logic                          fetch_req;
        logic [cpu_pkg::TAG_WIDTH-1:0] seen_tag;
        logic [cpu_pkg::TAG_WIDTH-1:0] wb_tag;
        logic                          result_valid;
        logic                          illegal;
        logic [31:0]                   result;
        logic [4:0]                    result_rd;

        logic                          dec_legal;
        cpu_pkg::opcode_e              dec_opcode;
        cpu_pkg::alu_op_e              dec_alu_op;

        logic                          pend_valid;
        logic                          pend_legal;
        cpu_pkg::opcode_e              pend_opcode;
        cpu_pkg::alu_op_e              pend_alu_op;
        logic [31:0]                   pend_imm_i;
        logic [19:0]                   pend_imm_u;
        logic [4:0]                    pend_rd;

        logic [31:0]                   alu_b;
        logic [31:0]                   alu_result;

        assign inst = i_fetch_data.instruction;
        assign fetch_req = i_fetch_data.tag != seen_tag;

        always_comb begin
                dec_legal = 1'b1;
                dec_opcode = cpu_pkg::OPC_OP;
                dec_alu_op = cpu_pkg::ALU_ADD;
                case (inst[6:0])
                cpu_pkg::OPC_OP: dec_opcode = cpu_pkg::OPC_OP;
                cpu_pkg::OPC_OP_IMM: dec_opcode = cpu_pkg::OPC_OP_IMM;
                cpu_pkg::OPC_LUI: dec_opcode = cpu_pkg::OPC_LUI;
                default: dec_legal = 1'b0;
                endcase
                // bit 30 only means sub for register operands, for addi it is immediate
                case (inst[14:12])
                3'b000: begin
                        if (dec_opcode == cpu_pkg::OPC_OP && inst[30]) begin
                                dec_alu_op = cpu_pkg::ALU_SUB;
                        end
                end
                3'b100: dec_alu_op = cpu_pkg::ALU_XOR;
                3'b110: dec_alu_op = cpu_pkg::ALU_OR;
                3'b111: dec_alu_op = cpu_pkg::ALU_AND;
                3'b010: dec_alu_op = cpu_pkg::ALU_SLT;
                default: begin
                        // shifts and sltu are not implemented
                        if (dec_opcode != cpu_pkg::OPC_LUI) begin
                                dec_legal = 1'b0;
                        end
                end
                endcase
                if (dec_opcode == cpu_pkg::OPC_LUI) begin
                        dec_alu_op = cpu_pkg::ALU_LUI;
                end
        end

        assign alu_b = (pend_opcode == cpu_pkg::OPC_OP) ? i_rs2 : pend_imm_i;

        always_comb begin
                case (pend_alu_op)
                cpu_pkg::ALU_SUB: alu_result = i_rs1 - alu_b;
                cpu_pkg::ALU_XOR: alu_result = i_rs1 ^ alu_b;
                cpu_pkg::ALU_OR: alu_result = i_rs1 | alu_b;
                cpu_pkg::ALU_AND: alu_result = i_rs1 & alu_b;
                cpu_pkg::ALU_SLT: alu_result = {31'b0, $signed(i_rs1) < $signed(alu_b)};
                cpu_pkg::ALU_LUI: alu_result = {pend_imm_u, 12'b0};
                default: alu_result = i_rs1 + alu_b;
                endcase
        end

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        seen_tag <= '0;
                        wb_tag <= '0;
                        pend_valid <= 1'b0;
                        result_valid <= 1'b0;
                        illegal <= 1'b0;
                end else begin
                        pend_valid <= 1'b0;
                        result_valid <= 1'b0;
                        illegal <= 1'b0;
                        if (fetch_req) begin
                                seen_tag <= i_fetch_data.tag;
                                pend_valid <= 1'b1;
                        end
                        // operands arrived on the same edge as the pending fields
                        if (pend_valid) begin
                                result_valid <= pend_legal;
                                illegal <= !pend_legal;
                                if (pend_legal) begin
                                        wb_tag <= wb_tag + 1'b1;
                                end
                        end
                end
        end

        always_ff @(posedge i_clock) begin
                if (fetch_req) begin
                        pend_legal <= dec_legal;
                        pend_opcode <= dec_opcode;
                        pend_alu_op <= dec_alu_op;
                        pend_imm_i <= {{20{inst[31]}}, inst[31:20]};
                        pend_imm_u <= inst[31:12];
                        pend_rd <= inst[11:7];
                end
                if (pend_valid) begin
                        result <= alu_result;
                        result_rd <= pend_rd;
                end
        end

        assign o_result_valid = result_valid;
        assign o_illegal = illegal;
        assign o_result = result;
        assign o_result_rd = result_rd;

        assign o_memory_data.rd = result;
        assign o_memory_data.inst_rd = result_rd;
        assign o_memory_data.tag = wb_tag;

        a_result_excl: assert property (
                @(posedge i_clock) disable iff (i_reset)
                !(o_result_valid && o_illegal)
        ) else $error("result and illegal flagged in the same cycle");

        // each instruction reports once, the pulse never stretches into the next cycle
        a_result_pulse: assert property (
                @(posedge i_clock) disable iff (i_reset)
                (o_result_valid || o_illegal) |=> !(o_result_valid || o_illegal)
        ) else $error("result pulse longer than one cycle");

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
        input  logic        i_clock,
        input  logic        i_reset,
        input  logic        i_instr_strobe,
        input  logic [31:0] i_instruction,
        output logic        o_result_valid,
        output logic [31:0] o_result,
        output logic [4:0]  o_result_rd,
        output logic        o_illegal
);

        cpu_pkg::fetch_data_t  fetch_data;
        cpu_pkg::memory_data_t memory_data;
        logic [31:0]           rs1;
        logic [31:0]           rs2;

        cpu_fetch u_fetch (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_instr_strobe (i_instr_strobe),
                .i_instruction  (i_instruction),
                .o_fetch_data   (fetch_data)
        );

        cpu_registers u_registers (
                .i_reset        (i_reset),
                .i_clock        (i_clock),
                .i_fetch_data   (fetch_data),
                .o_rs1          (rs1),
                .o_rs2          (rs2),
                .i_memory_data  (memory_data)
        );

        cpu_execute u_execute (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_fetch_data   (fetch_data),
                .i_rs1          (rs1),
                .i_rs2          (rs2),
                .o_memory_data  (memory_data),
                .o_result_valid (o_result_valid),
                .o_result       (o_result),
                .o_result_rd    (o_result_rd),
                .o_illegal      (o_illegal)
        );

endmodule

// File: tests/cpu_lfsr.svh
`ifndef CPU_LFSR_SVH
`define CPU_LFSR_SVH

// the galois form of x^32 + x^22 + x^2 + x + 1 shifts right
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
                return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
endfunction

// each bit taken costs one step and the lsb is filled first
function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
                lfsr_state = lfsr_step(lfsr_state);
                value[i] = lfsr_state[0];
        end
        return value;
endfunction

`endif

// File: tests/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

        `include "cpu_lfsr.svh"

        localparam int RESET_CYCLES = 10;
        localparam int INSTR_COUNT = 2 + 100 + 100 + 40 + 20 + 40;
        localparam int CYCLE_LIMIT = RESET_CYCLES + 4 * INSTR_COUNT + 50;

        logic        i_clock;
        logic        i_reset;
        logic        i_instr_strobe;
        logic [31:0] i_instruction;
        logic        o_result_valid;
        logic [31:0] o_result;
        logic [4:0]  o_result_rd;
        logic        o_illegal;

        logic [31:0] model_regs [32];
        int          cycle_count = 0;
        int          check_count = 0;
        int          error_count = 0;
        int          test_count = 0;
        int          test_checks;
        int          test_errors;
        string       test_name;

        cpu_core dut0 (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_instr_strobe (i_instr_strobe),
                .i_instruction  (i_instruction),
                .o_result_valid (o_result_valid),
                .o_result       (o_result),
                .o_result_rd    (o_result_rd),
                .o_illegal      (o_illegal)
        );

        always #50 i_clock = ~i_clock;

        always @(posedge i_clock) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("RESULT: FAIL");
                        $finish;
                end
        end

        function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                                    input logic [4:0] rs1, input logic [2:0] funct3,
                                                    input logic [4:0] rd);
                return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
        endfunction

        function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                    input logic [2:0] funct3, input logic [4:0] rd);
                return {imm, rs1, funct3, rd, 7'b0010011};
        endfunction

        function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
                return {imm, rd, 7'b0110111};
        endfunction

        function automatic logic [31:0] read_model(input logic [4:0] index);
                return (index == 5'd0) ? 32'h0 : model_regs[index];
        endfunction

        function automatic logic known_opcode(input logic [31:0] instr);
                return instr[6:0] == 7'b0110011 || instr[6:0] == 7'b0010011 ||
                       instr[6:0] == 7'b0110111;
        endfunction

        // expected value from the instruction rules and the model registers
        function automatic logic [31:0] model_result(input logic [31:0] instr);
                logic [31:0] a;
                logic [31:0] b;
                logic        reg_op;
                reg_op = instr[6:0] == 7'b0110011;
                a = read_model(instr[19:15]);
                b = reg_op ? read_model(instr[24:20]) : {{20{instr[31]}}, instr[31:20]};
                if (instr[6:0] == 7'b0110111) begin
                        return {instr[31:12], 12'h000};
                end
                case (instr[14:12])
                3'b000: return (reg_op && instr[30]) ? a - b : a + b;
                3'b100: return a ^ b;
                3'b110: return a | b;
                3'b111: return a & b;
                3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: return 32'h0;
                endcase
        endfunction

        task automatic report_error(input string signal, input logic [31:0] expected,
                                    input logic [31:0] actual);
                $display("Error %s expected %08h actual %08h", signal, expected, actual);
                error_count++;
                test_errors++;
        endtask

        // called at a rising edge and returns at the edge where the writeback lands
        task automatic issue_and_check(input logic [31:0] instr);
                logic [31:0] expected;
                logic        legal;
                legal = known_opcode(instr);
                expected = model_result(instr);
                i_instr_strobe <= 1'b1;
                i_instruction <= instr;
                @(posedge i_clock);
                i_instr_strobe <= 1'b0;
                @(posedge i_clock);
                @(posedge i_clock);
                @(negedge i_clock);
                check_count++;
                test_checks++;
                if (legal) begin
                        if (o_result_valid !== 1'b1) begin
                                $display("no result pulse two cycles after instruction %08h", instr);
                                error_count++;
                                test_errors++;
                        end else begin
                                if (o_result !== expected) begin
                                        report_error("o_result", expected, o_result);
                                end
                                if (o_result_rd !== instr[11:7]) begin
                                        report_error("o_result_rd", 32'(instr[11:7]),
                                                     32'(o_result_rd));
                                end
                        end
                        if (o_illegal !== 1'b0) begin
                                report_error("o_illegal", 32'h0, 32'(o_illegal));
                        end
                        model_regs[instr[11:7]] = expected;
                end else begin
                        if (o_illegal !== 1'b1) begin
                                $display("no illegal pulse for unknown opcode in %08h", instr);
                                error_count++;
                                test_errors++;
                        end
                        if (o_result_valid !== 1'b0) begin
                                report_error("o_result_valid", 32'h0, 32'(o_result_valid));
                        end
                end
                @(posedge i_clock);
        endtask

        task automatic start_test(input string name);
                test_name = name;
                test_checks = 0;
                test_errors = 0;
        endtask

        task automatic end_test();
                test_count++;
                $display("test %s done, %0d checks, %0d errors", test_name, test_checks,
                         test_errors);
        endtask

        initial begin
                logic [2:0]  funct3_table [6];
                logic [31:0] word;
                logic [4:0]  rd;
                int          sel;
                funct3_table = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b010};
                i_clock = 1'b0;
                i_reset = 1'b1;
                i_instr_strobe = 1'b0;
                i_instruction = 32'h0;
                lfsr_state = 32'h279a;
                for (int i = 0; i < 32; i++) begin
                        model_regs[i] = 32'h0;
                end
                model_regs[2] = cpu_pkg::SP_RESET;
                repeat (RESET_CYCLES) @(posedge i_clock);
                i_reset <= 1'b0;
                @(posedge i_clock);

                start_test("reset_values");
                issue_and_check(r_type_word(7'h00, 5'd0, 5'd2, 3'b000, 5'd5));
                issue_and_check(r_type_word(7'h00, 5'd0, 5'd7, 3'b000, 5'd6));
                end_test();

                // immediates first so the register operands are no longer all zero
                start_test("i_type");
                for (int i = 0; i < 100; i++) begin
                        sel = 1 + random_bits(3) % 5;
                        issue_and_check(i_type_word(12'(random_bits(12)), 5'(random_bits(5)),
                                                    funct3_table[sel], 5'(random_bits(5))));
                end
                end_test();

                start_test("r_type");
                for (int i = 0; i < 100; i++) begin
                        sel = random_bits(3) % 6;
                        issue_and_check(r_type_word((sel == 1) ? 7'h20 : 7'h00,
                                                    5'(random_bits(5)), 5'(random_bits(5)),
                                                    funct3_table[sel], 5'(random_bits(5))));
                end
                end_test();

                start_test("lui");
                for (int i = 0; i < 20; i++) begin
                        rd = 5'(random_bits(5));
                        if (rd == 5'd0) begin
                                rd = 5'd1;
                        end
                        issue_and_check(lui_word(20'(random_bits(20)), rd));
                        issue_and_check(r_type_word(7'h00, 5'd0, rd, 3'b000,
                                                    5'(random_bits(5))));
                end
                end_test();

                start_test("x0_target");
                for (int i = 0; i < 10; i++) begin
                        issue_and_check(i_type_word(12'(random_bits(12)), 5'(random_bits(5)),
                                                    3'b000, 5'd0));
                        issue_and_check(r_type_word(7'h00, 5'd0, 5'd0, 3'b110,
                                                    5'(random_bits(5))));
                end
                end_test();

                start_test("illegal_opcode");
                for (int i = 0; i < 20; i++) begin
                        word = random_bits(32);
                        if (known_opcode(word)) begin
                                word[0] = ~word[0];
                        end
                        issue_and_check(word);
                        issue_and_check(r_type_word(7'h00, 5'd0, word[11:7], 3'b000,
                                                    5'(random_bits(5))));
                end
                end_test();

                $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
                if (error_count == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

// File: verilog.f
+incdir+tests
src/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_registers.sv
src/cpu_execute.sv
src/cpu_core.sv
tests/cpu_core_tb.sv
